//--- hw/rv_core_pkg.sv
/* rv64 core shared constants */

package rv_core_pkg;

  // first fetch address after reset
  localparam logic [63:0] reset_pc = 64'h0000_0000_8000_0000;

  // major opcodes, inst[6:0]
  localparam logic [6:0] op_lui    = 7'b0110111;
  localparam logic [6:0] op_auipc  = 7'b0010111;
  localparam logic [6:0] op_op_imm = 7'b0010011;
  localparam logic [6:0] op_op     = 7'b0110011;
  localparam logic [6:0] op_jal    = 7'b1101111;
  localparam logic [6:0] op_system = 7'b1110011;

  // add/addi/sub share funct3
  localparam logic [2:0] funct3_add = 3'b000;

  // funct7 splits add from sub
  localparam logic [6:0] funct7_base = 7'b0000000;
  localparam logic [6:0] funct7_sub  = 7'b0100000;

  // the one system encoding the core accepts
  localparam logic [31:0] inst_ebreak = 32'h0010_0073;

  // alu operation select
  typedef enum logic [1:0] {
    alu_add,
    alu_sub,
    alu_pass_b
  } alu_op_e;

endpackage

//--- hw/inst_mem.sv
/* instruction memory */

`timescale 1ns/1ps

module inst_mem #(
  parameter int unsigned xlen       = 64,
  parameter int unsigned imem_depth = 256,
  parameter logic [xlen-1:0] base_addr = '0
) (
  input  logic                          clk,
  input  logic                          load_en,
  input  logic [$clog2(imem_depth)-1:0] load_addr,
  input  logic [31:0]                   load_data,
  input  logic [xlen-1:0]               pc,
  output logic [31:0]                   inst
);

  localparam int unsigned aw = $clog2(imem_depth);

  // program words, no reset
  logic [31:0] mem [imem_depth];

  logic [xlen-1:0] offset;
  logic [xlen-3:0] word_idx;
  logic            in_range;

  // load port, only driven while the core sits in reset
  always_ff @(posedge clk) begin
    if (load_en) begin
      mem[load_addr] <= load_data;
    end
  end

  // pc below base wraps high and lands out of range
  assign offset   = pc - base_addr;
  assign word_idx = offset[xlen-1:2];
  assign in_range = word_idx < (xlen-2)'(imem_depth);

  // zero word decodes as illegal, so a runaway pc stops the core
  assign inst = in_range ? mem[word_idx[aw-1:0]] : 32'h0;

  // fetch unit must only ever produce aligned targets
  a_pc_aligned: assert property (@(posedge clk) pc[1:0] == 2'b00)
    else $error("fetch pc %h not word aligned", pc);

endmodule

//--- hw/fetch_unit.sv
/* program counter and halt */

`timescale 1ns/1ps

module fetch_unit import rv_core_pkg::*; #(
  parameter int unsigned xlen = 64
) (
  input  logic            clk,
  input  logic            rst_n,
  input  logic            is_jal,
  input  logic [xlen-1:0] imm,
  input  logic            stop,
  output logic [xlen-1:0] pc,
  output logic            halted,
  output logic            running
);

  logic [xlen-1:0] next_pc;

  // out of reset and not yet stopped
  assign running = rst_n && !halted;

  // jal jumps by its offset, everything else steps one word
  assign next_pc = is_jal ? pc + imm : pc + xlen'(4);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pc     <= reset_pc[xlen-1:0];
      halted <= 1'b0;
    end else if (running) begin
      if (stop) begin
        // pc stays on the stopping instruction
        halted <= 1'b1;
      end else begin
        pc <= next_pc;
      end
    end
  end

  // once halted the core is frozen for good
  a_pc_frozen: assert property (
    @(posedge clk) disable iff (!rst_n) halted |=> $stable(pc) && halted
  ) else $error("pc moved after halt");

endmodule

//--- hw/inst_decoder.sv
/* instruction decoder */

`timescale 1ns/1ps

module inst_decoder import rv_core_pkg::*; #(
  parameter int unsigned xlen = 64
) (
  input  logic [31:0]     inst,
  output logic [4:0]      rd,
  output logic [4:0]      rs1,
  output logic [4:0]      rs2,
  output logic [xlen-1:0] imm,
  output logic [xlen-1:0] imm_link,
  output logic            use_imm,
  output logic            use_pc,
  output alu_op_e         alu_op,
  output logic            rd_wen,
  output logic            is_jal,
  output logic            is_ebreak,
  output logic            illegal
);

  logic [6:0]      opcode;
  logic [2:0]      funct3;
  logic [6:0]      funct7;
  logic [xlen-1:0] imm_i;
  logic [xlen-1:0] imm_u;
  logic [xlen-1:0] imm_j;
  logic            writes_rd;

  // fixed field positions
  assign opcode = inst[6:0];
  assign rd     = inst[11:7];
  assign funct3 = inst[14:12];
  assign rs1    = inst[19:15];
  assign rs2    = inst[24:20];
  assign funct7 = inst[31:25];

  // immediates, all sign extended from inst[31]
  assign imm_i = {{(xlen-12){inst[31]}}, inst[31:20]};
  assign imm_u = {{(xlen-32){inst[31]}}, inst[31:12], 12'h000};
  assign imm_j = {{(xlen-21){inst[31]}}, inst[31], inst[19:12], inst[20],
                  inst[30:21], 1'b0};

  // link value is pc + 4, alu adds this to pc
  assign imm_link = xlen'(4);

  always_comb begin
    // defaults: no write, not recognised
    imm       = imm_i;
    use_imm   = 1'b0;
    use_pc    = 1'b0;
    alu_op    = alu_add;
    writes_rd = 1'b0;
    is_jal    = 1'b0;
    is_ebreak = 1'b0;
    illegal   = 1'b0;
    case (opcode)
      op_lui: begin
        imm       = imm_u;
        use_imm   = 1'b1;
        alu_op    = alu_pass_b;
        writes_rd = 1'b1;
      end
      op_auipc: begin
        imm       = imm_u;
        use_imm   = 1'b1;
        use_pc    = 1'b1;
        writes_rd = 1'b1;
      end
      op_op_imm: begin
        // addi only
        use_imm   = 1'b1;
        writes_rd = funct3 == funct3_add;
        illegal   = funct3 != funct3_add;
      end
      op_op: begin
        if (funct3 == funct3_add && funct7 == funct7_base) begin
          writes_rd = 1'b1;
        end else if (funct3 == funct3_add && funct7 == funct7_sub) begin
          alu_op    = alu_sub;
          writes_rd = 1'b1;
        end else begin
          illegal = 1'b1;
        end
      end
      op_jal: begin
        // imm carries the jump offset to fetch
        imm       = imm_j;
        use_pc    = 1'b1;
        is_jal    = 1'b1;
        writes_rd = 1'b1;
      end
      op_system: begin
        is_ebreak = inst == inst_ebreak;
        illegal   = inst != inst_ebreak;
      end
      default: begin
        illegal = 1'b1;
      end
    endcase
  end

  // x0 is never written
  assign rd_wen = writes_rd && (rd != 5'd0);

endmodule

//--- hw/reg_file.sv
/* integer register file */

`timescale 1ns/1ps

module reg_file #(
  parameter int unsigned xlen = 64
) (
  input  logic            clk,
  input  logic            rst_n,
  input  logic            wen,
  input  logic [4:0]      waddr,
  input  logic [xlen-1:0] wdata,
  input  logic [4:0]      raddr_a,
  input  logic [4:0]      raddr_b,
  output logic [xlen-1:0] rdata_a,
  output logic [xlen-1:0] rdata_b
);

  // x1..x31, x0 has no storage
  logic [xlen-1:0] regs [1:31];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wen && waddr != 5'd0) begin
      regs[waddr] <= wdata;
    end
  end

  // combinational reads, new value shows next cycle
  assign rdata_a = (raddr_a == 5'd0) ? '0 : regs[raddr_a];
  assign rdata_b = (raddr_b == 5'd0) ? '0 : regs[raddr_b];

  // decoder already masks rd == 0 out of the enable
  a_no_x0_write: assert property (
    @(posedge clk) disable iff (!rst_n) !(wen && waddr == 5'd0)
  ) else $error("write enable raised for x0");

endmodule

//--- hw/alu.sv
/* add/sub alu */

`timescale 1ns/1ps

module alu import rv_core_pkg::*; #(
  parameter int unsigned xlen = 64
) (
  input  logic [xlen-1:0] a,
  input  logic [xlen-1:0] b,
  input  alu_op_e         op,
  output logic [xlen-1:0] result
);

  always_comb begin
    case (op)
      alu_add: begin
        // addi, add, auipc and the jal link
        result = a + b;
      end
      alu_sub: begin
        result = a - b;
      end
      alu_pass_b: begin
        // lui, u immediate straight through
        result = b;
      end
      default: begin
        result = '0;
      end
    endcase
  end

endmodule

//--- hw/rv_core_top.sv
/* single cycle rv64 core */

`timescale 1ns/1ps

module rv_core_top import rv_core_pkg::*; #(
  parameter int unsigned xlen       = 64,
  parameter int unsigned imem_depth = 256
) (
  input  logic                          clk,
  input  logic                          rst_n,
  input  logic                          load_en,
  input  logic [$clog2(imem_depth)-1:0] load_addr,
  input  logic [31:0]                   load_data,
  output logic                          commit_valid,
  output logic [xlen-1:0]               commit_pc,
  output logic [4:0]                    commit_rd,
  output logic [xlen-1:0]               commit_data,
  output logic                          halted,
  output logic                          illegal_seen
);

  logic [xlen-1:0] pc;
  logic [31:0]     inst;
  logic            running;

  // decode outputs
  logic [4:0]      rd;
  logic [4:0]      rs1;
  logic [4:0]      rs2;
  logic [xlen-1:0] imm;
  logic [xlen-1:0] imm_link;
  logic            use_imm;
  logic            use_pc;
  alu_op_e         alu_op;
  logic            rd_wen;
  logic            is_jal;
  logic            is_ebreak;
  logic            illegal;

  // execute and write back
  logic [xlen-1:0] rs1_data;
  logic [xlen-1:0] rs2_data;
  logic [xlen-1:0] op_a;
  logic [xlen-1:0] op_b;
  logic [xlen-1:0] result;
  logic [xlen-1:0] wb_data;
  logic            reg_wen;
  logic            stop;

  inst_mem #(
    .xlen       (xlen),
    .imem_depth (imem_depth),
    .base_addr  (reset_pc[xlen-1:0])
  ) i_inst_mem (
    .clk       (clk),
    .load_en   (load_en),
    .load_addr (load_addr),
    .load_data (load_data),
    .pc        (pc),
    .inst      (inst)
  );

  assign stop = is_ebreak || illegal;

  fetch_unit #(
    .xlen (xlen)
  ) i_fetch_unit (
    .clk     (clk),
    .rst_n   (rst_n),
    .is_jal  (is_jal),
    .imm     (imm),
    .stop    (stop),
    .pc      (pc),
    .halted  (halted),
    .running (running)
  );

  inst_decoder #(
    .xlen (xlen)
  ) i_inst_decoder (
    .inst      (inst),
    .rd        (rd),
    .rs1       (rs1),
    .rs2       (rs2),
    .imm       (imm),
    .imm_link  (imm_link),
    .use_imm   (use_imm),
    .use_pc    (use_pc),
    .alu_op    (alu_op),
    .rd_wen    (rd_wen),
    .is_jal    (is_jal),
    .is_ebreak (is_ebreak),
    .illegal   (illegal)
  );

  // no writes in reset or after halt
  assign reg_wen = rd_wen && running;

  reg_file #(
    .xlen (xlen)
  ) i_reg_file (
    .clk     (clk),
    .rst_n   (rst_n),
    .wen     (reg_wen),
    .waddr   (rd),
    .wdata   (wb_data),
    .raddr_a (rs1),
    .raddr_b (rs2),
    .rdata_a (rs1_data),
    .rdata_b (rs2_data)
  );

  // operand a: pc for auipc and jal
  assign op_a = use_pc ? pc : rs1_data;
  // operand b: jal takes the link step, its imm goes to fetch
  assign op_b = is_jal ? imm_link : (use_imm ? imm : rs2_data);

  alu #(
    .xlen (xlen)
  ) i_alu (
    .a      (op_a),
    .b      (op_b),
    .op     (alu_op),
    .result (result)
  );

  assign wb_data = result;

  // commit trace, rd and data zeroed when nothing is written
  assign commit_valid = running;
  assign commit_pc    = pc;
  assign commit_rd    = reg_wen ? rd : 5'd0;
  assign commit_data  = reg_wen ? wb_data : '0;

  // sticky, set on the same edge that halts the core
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      illegal_seen <= 1'b0;
    end else if (running && illegal) begin
      illegal_seen <= 1'b1;
    end
  end

  // program load belongs to reset only
  a_load_in_reset: assert property (@(posedge clk) !(load_en && rst_n))
    else $error("load_en high outside reset");

endmodule

//--- testbench/tb_rv_core.sv
/* rv64 core testbench */

`timescale 1ns/1ps

module tb_rv_core;

  localparam int unsigned     xlen       = 64;
  localparam int unsigned     imem_depth = 256;
  localparam int unsigned     aw         = $clog2(imem_depth);
  localparam int              clk_period = 40;
  localparam logic [xlen-1:0] reset_addr = 64'h0000_0000_8000_0000;
  localparam string           stim_file  = "testbench/core_stimulus.txt";

  logic            clk = 1'b0;
  logic            rst_n;
  logic            load_en;
  logic [aw-1:0]   load_addr;
  logic [31:0]     load_data;
  logic            commit_valid;
  logic [xlen-1:0] commit_pc;
  logic [4:0]      commit_rd;
  logic [xlen-1:0] commit_data;
  logic            halted;
  logic            illegal_seen;

  int          fd;
  int          pass_count;
  int          fail_count;
  int          reset_cycles;
  bit          in_reset;
  bit          armed;
  time         deadline;
  int unsigned seed_val;

  // expected commit trace, one entry per E record
  logic [127:0]    exp_name [$];
  logic [xlen-1:0] exp_pc [$];
  logic [4:0]      exp_rd [$];
  logic [xlen-1:0] exp_data [$];

  // commit checker scratch
  logic [127:0]    c_name;
  logic [xlen-1:0] c_pc;
  logic [4:0]      c_rd;
  logic [xlen-1:0] c_data;
  bit              c_ok;

  always #(clk_period / 2) clk = ~clk;

  rv_core_top #(
    .xlen       (xlen),
    .imem_depth (imem_depth)
  ) i_dut (
    .clk          (clk),
    .rst_n        (rst_n),
    .load_en      (load_en),
    .load_addr    (load_addr),
    .load_data    (load_data),
    .commit_valid (commit_valid),
    .commit_pc    (commit_pc),
    .commit_rd    (commit_rd),
    .commit_data  (commit_data),
    .halted       (halted),
    .illegal_seen (illegal_seen)
  );

  // counts, verdict, end of simulation
  task automatic close_run();
    $display("tests passed %0d failed %0d", pass_count, fail_count);
    if (fail_count == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  endtask

  task automatic enter_reset();
    @(negedge clk);
    rst_n        = 1'b0;
    reset_cycles = 1;
    in_reset     = 1'b1;
  endtask

  // one program word per falling edge, written on the next rising edge
  task automatic load_word(input int idx, input logic [31:0] word);
    @(negedge clk);
    load_en   = 1'b1;
    load_addr = aw'(idx);
    load_data = word;
    reset_cycles++;
  endtask

  task automatic check_reset_state();
    if (commit_pc !== reset_addr) begin
      $display("MISMATCH reset_pc expected %h actual %h", reset_addr, commit_pc);
      fail_count++;
    end else if (commit_valid !== 1'b0 || halted !== 1'b0 || illegal_seen !== 1'b0) begin
      $display("ERROR commit or status output active during reset");
      fail_count++;
    end else begin
      $display("PASS reset_state");
      pass_count++;
    end
  endtask

  task automatic check_final(input int h_val, input int i_val);
    if (exp_pc.size() != 0) begin
      $display("ERROR %0d expected commits never appeared", exp_pc.size());
      fail_count++;
      exp_name.delete();
      exp_pc.delete();
      exp_rd.delete();
      exp_data.delete();
    end
    if (halted !== h_val[0] || illegal_seen !== i_val[0]) begin
      $display("MISMATCH final_status expected halted %0d illegal %0d actual halted %0b illegal %0b",
               h_val, i_val, halted, illegal_seen);
      fail_count++;
    end else begin
      $display("PASS final_status");
      pass_count++;
    end
  endtask

  // release reset, let the core run to its halt, then check the end state
  task automatic run_section(input int h_val, input int i_val);
    int hold;
    int n_exp;
    if (!in_reset) begin
      enter_reset();
    end
    @(negedge clk);
    load_en = 1'b0;
    reset_cycles++;
    // at least ten reset cycles, plus a few random idle ones
    hold = (reset_cycles > 10 ? reset_cycles : 10) + int'($urandom % 4);
    while (reset_cycles < hold) begin
      @(negedge clk);
      reset_cycles++;
    end
    check_reset_state();
    n_exp    = exp_pc.size();
    deadline = $time + 64'(clk_period * (n_exp + 50));
    armed    = 1'b1;
    rst_n    = 1'b1;
    while (!halted) begin
      @(negedge clk);
    end
    armed = 1'b0;
    // a few more cycles so a stray commit after halt gets caught
    repeat (3) @(negedge clk);
    check_final(h_val, i_val);
    in_reset = 1'b0;
  endtask

  task automatic process_file();
    logic [7:0]       tag;
    logic [127:0]     name;
    logic [xlen-1:0]  pc_val;
    logic [xlen-1:0]  data_val;
    logic [31:0]      word;
    logic [8*128-1:0] rest;
    int               idx;
    int               rd_val;
    int               h_val;
    int               i_val;
    int               code;
    while ($fscanf(fd, "%s", tag) == 1) begin
      if (tag == "#") begin
        code = $fgets(rest, fd);
      end else if (tag == "P") begin
        code = $fscanf(fd, "%d %h", idx, word);
        if (!in_reset) begin
          enter_reset();
        end
        load_word(idx, word);
      end else if (tag == "E") begin
        code = $fscanf(fd, "%s %h %d %h", name, pc_val, rd_val, data_val);
        exp_name.push_back(name);
        exp_pc.push_back(pc_val);
        exp_rd.push_back(5'(rd_val));
        exp_data.push_back(data_val);
      end else if (tag == "X") begin
        code = $fscanf(fd, "%d %d", h_val, i_val);
        run_section(h_val, i_val);
      end else begin
        $display("ERROR unknown record type in stimulus file");
        fail_count++;
      end
    end
  endtask

  // commit port, sampled on the edge that retires the instruction
  always @(posedge clk) begin
    if (commit_valid === 1'b1) begin
      if (exp_pc.size() == 0) begin
        $display("ERROR unexpected commit at pc %h with nothing left to expect", commit_pc);
        fail_count++;
      end else begin
        c_name = exp_name.pop_front();
        c_pc   = exp_pc.pop_front();
        c_rd   = exp_rd.pop_front();
        c_data = exp_data.pop_front();
        c_ok   = 1'b1;
        if (commit_pc !== c_pc) begin
          $display("MISMATCH %0s pc expected %h actual %h", c_name, c_pc, commit_pc);
          c_ok = 1'b0;
        end
        if (commit_rd !== c_rd) begin
          $display("MISMATCH %0s rd expected %0d actual %0d", c_name, c_rd, commit_rd);
          c_ok = 1'b0;
        end
        if (commit_data !== c_data) begin
          $display("MISMATCH %0s data expected %h actual %h", c_name, c_data, commit_data);
          c_ok = 1'b0;
        end
        if (c_ok) begin
          $display("PASS %0s", c_name);
          pass_count++;
        end else begin
          fail_count++;
        end
      end
    end
  end

  // watchdog, armed only while a program runs
  initial begin
    @(posedge clk);
    while (!(armed && $time > deadline)) begin
      @(posedge clk);
    end
    $display("ERROR core never halted before the time limit");
    fail_count++;
    close_run();
  end

  initial begin
    seed_val     = $urandom(61);
    rst_n        = 1'b0;
    load_en      = 1'b0;
    load_addr    = '0;
    load_data    = '0;
    pass_count   = 0;
    fail_count   = 0;
    reset_cycles = 0;
    in_reset     = 1'b0;
    armed        = 1'b0;
    deadline     = 0;
    fd = $fopen(stim_file, "r");
    if (fd == 0) begin
      $display("ERROR cannot open stimulus file %0s", stim_file);
      fail_count++;
      close_run();
    end else begin
      process_file();
      $fclose(fd);
      close_run();
    end
  end

endmodule

//--- testbench/core_stimulus.txt
# P word_index instruction | E test_name pc rd data | X halted illegal
# each X record runs the program loaded since the previous X
# run 1: addi, add, sub, x0, lui, auipc, jal, ebreak
P 0 00500093
P 1 FFD08113
P 2 80000193
P 3 7FF18213
P 4 002082B3
P 5 40110333
P 6 001203B3
P 7 40418433
P 8 00208033
P 9 001004B3
P 10 12345537
P 11 800005B7
P 12 00001617
P 13 FFFFF697
P 14 0100076F
P 15 00100793
P 16 06400813
P 17 00C0006F
P 18 FF9FF8EF
P 19 00700913
P 20 011809B3
P 21 00100073
E addi_pos 80000000 1 0000000000000005
E addi_neg 80000004 2 0000000000000002
E addi_min 80000008 3 FFFFFFFFFFFFF800
E addi_max 8000000C 4 FFFFFFFFFFFFFFFF
E add_regs 80000010 5 0000000000000007
E sub_neg 80000014 6 FFFFFFFFFFFFFFFD
E add_wrap 80000018 7 0000000000000004
E sub_wrap 8000001C 8 FFFFFFFFFFFFF801
E add_to_x0 80000020 0 0000000000000000
E read_x0 80000024 9 0000000000000005
E lui_pos 80000028 10 0000000012345000
E lui_neg 8000002C 11 FFFFFFFF80000000
E auipc_pos 80000030 12 0000000080001030
E auipc_neg 80000034 13 000000007FFFF034
E jal_fwd 80000038 14 000000008000003C
E jal_back 80000048 17 000000008000004C
E addi_target 80000040 16 0000000000000064
E jal_x0 80000044 0 0000000000000000
E add_link 80000050 19 00000000800000B0
E ebreak 80000054 0 0000000000000000
X 1 0
# run 2: stops on an unsupported op encoding
P 0 00900093
P 1 00108133
P 2 022081B3
P 3 00100213
E run2_addi 80000000 1 0000000000000009
E run2_add 80000004 2 0000000000000012
E run2_illegal 80000008 0 0000000000000000
X 1 1

//--- tb.f
hw/rv_core_pkg.sv
hw/inst_mem.sv
hw/fetch_unit.sv
hw/inst_decoder.sv
hw/reg_file.sv
hw/alu.sv
hw/rv_core_top.sv
testbench/tb_rv_core.sv

//--- run_sim.sh
#!/bin/sh
# build the rv core testbench with verilator and run it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -j 0 --top-module tb_rv_core -f tb.f -o vsim
status=$?
if [ $status -ne 0 ]; then
  echo "verilator build failed with status $status"
  exit 1
fi

output=$(./obj_dir/vsim)
status=$?
printf '%s\n' "$output"
if [ $status -ne 0 ]; then
  echo "simulation binary exited with status $status"
  exit 1
fi

if printf '%s\n' "$output" | grep -q "Simulation completed successfully"; then
  exit 0
fi
exit 1
